// File: common/vrename_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Vector register renaming shared sizes and types
// Architectural and physical register names, free list and checkpoint labels
////////////////////////////////////////////////////////////////////////////

package vrename_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////

    // Architectural vector registers seen by software
    localparam int NUM_ISA_VREGS = 32;

    // Physical vector registers in the register file
    localparam int NUM_PHYS_VREGS = 64;

    // Registers not held by the committed map live in the free list
    localparam int NUM_FREE_ENTRIES = NUM_PHYS_VREGS - NUM_ISA_VREGS;

    // Copies of map and free list pointers, one is always the active one
    localparam int NUM_CHECKPOINTS = 4;

    ////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////

    // Architectural register name, 5 bits
    typedef logic [$clog2(NUM_ISA_VREGS)-1:0] isa_vreg_t;

    // Physical register name, 6 bits
    typedef logic [$clog2(NUM_PHYS_VREGS)-1:0] phvreg_t;

    // Checkpoint label, wraps modulo NUM_CHECKPOINTS
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0] checkpoint_ptr_t;

    // Index into the circular free list, wraps modulo NUM_FREE_ENTRIES
    typedef logic [$clog2(NUM_FREE_ENTRIES)-1:0] free_ptr_t;

endpackage

// File: free_list/vreg_free_list.sv
////////////////////////////////////////////////////////////////////////////
// Vector register free list
// Circular buffer of free physical registers with one head and count per
// checkpoint, a shared tail, and checkpoint label bookkeeping
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vreg_free_list (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          read_head_i,          // Rename wants a register
    input  logic [1:0]                    add_free_register_i,  // Release strobes
    input  vrename_pkg::phvreg_t [1:0]    free_register_i,      // Released names
    input  logic                          do_checkpoint_i,
    input  logic                          do_recover_i,
    input  vrename_pkg::checkpoint_ptr_t  recover_checkpoint_i,
    input  logic                          delete_checkpoint_i,  // Retire oldest
    input  logic                          commit_roll_back_i,
    output vrename_pkg::phvreg_t          new_register_o,       // Zero when not granted
    output logic                          rename_grant_o,
    output vrename_pkg::checkpoint_ptr_t  checkpoint_o,
    output logic                          out_of_checkpoints_o,
    output logic                          empty_o
);

    // Count needs one bit more than the index to hold a full list
    typedef logic [$clog2(vrename_pkg::NUM_FREE_ENTRIES):0] free_cnt_t;

    vrename_pkg::phvreg_t register_table [vrename_pkg::NUM_FREE_ENTRIES];

    vrename_pkg::free_ptr_t head [vrename_pkg::NUM_CHECKPOINTS];  // One head per copy
    free_cnt_t num_registers [vrename_pkg::NUM_CHECKPOINTS];     // Free count per copy
    vrename_pkg::free_ptr_t tail;
    vrename_pkg::free_ptr_t tail_plus_one;

    vrename_pkg::checkpoint_ptr_t version_head;  // Active copy
    vrename_pkg::checkpoint_ptr_t version_tail;  // Oldest live copy
    vrename_pkg::checkpoint_ptr_t next_version;

    logic [$clog2(vrename_pkg::NUM_CHECKPOINTS):0] num_checkpoints;  // Live checkpoints

    logic       write_enable_0;
    logic       write_enable_1;
    logic       read_enable;
    logic       checkpoint_enable;
    logic       delete_enable;
    logic [1:0] wr_count;       // Releases taken this cycle
    logic       active_empty;   // Active copy holds nothing

    ////////////////////////////////////////////////////////////////////////
    // Enables
    ////////////////////////////////////////////////////////////////////////

    assign write_enable_0 = add_free_register_i[0] & ~commit_roll_back_i;
    assign write_enable_1 = add_free_register_i[1] & ~commit_roll_back_i;
    assign wr_count       = {1'b0, write_enable_0} + {1'b0, write_enable_1};

    assign active_empty = (num_registers[version_head] == '0);

    // A same-cycle release makes a register available even when empty
    assign read_enable = read_head_i & (~active_empty | write_enable_0 | write_enable_1)
                       & ~do_recover_i & ~commit_roll_back_i;

    assign checkpoint_enable = do_checkpoint_i & ~out_of_checkpoints_o
                             & ~do_recover_i & ~commit_roll_back_i;

    // Nothing to retire when no checkpoint is live
    assign delete_enable = delete_checkpoint_i & (num_checkpoints != '0)
                         & ~do_recover_i & ~commit_roll_back_i;

    assign tail_plus_one = tail + 1'b1;
    assign next_version  = version_head + 1'b1;

    ////////////////////////////////////////////////////////////////////////
    // State update
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            version_head    <= '0;
            version_tail    <= '0;
            num_checkpoints <= '0;
            tail            <= '0;
            checkpoint_o    <= '0;
            for (int c = 0; c < vrename_pkg::NUM_CHECKPOINTS; c++) begin
                head[c]          <= '0;
                num_registers[c] <= free_cnt_t'(vrename_pkg::NUM_FREE_ENTRIES);  // Full
            end
            // Registers above the identity map start out free
            for (int e = 0; e < vrename_pkg::NUM_FREE_ENTRIES; e++) begin
                register_table[e] <= vrename_pkg::phvreg_t'(vrename_pkg::NUM_ISA_VREGS + e);
            end
        end else if (commit_roll_back_i) begin
            // Everything since the committed state returns to the list
            version_head     <= '0;
            version_tail     <= '0;
            num_checkpoints  <= '0;
            head[0]          <= tail;
            num_registers[0] <= free_cnt_t'(vrename_pkg::NUM_FREE_ENTRIES);
            checkpoint_o     <= '0;
        end else begin
            checkpoint_o <= version_head;                  // Label seen one cycle late
            version_tail <= version_tail + delete_enable;

            // Releases land at the tail, second one behind the first
            if (write_enable_0) begin
                register_table[tail] <= free_register_i[0];
                if (write_enable_1) begin
                    register_table[tail_plus_one] <= free_register_i[1];
                end
            end else if (write_enable_1) begin
                register_table[tail] <= free_register_i[1];
            end
            tail <= tail + vrename_pkg::free_ptr_t'(wr_count);

            // Every copy sees the released registers
            for (int c = 0; c < vrename_pkg::NUM_CHECKPOINTS; c++) begin
                num_registers[c] <= num_registers[c] + free_cnt_t'(wr_count);
            end

            if (do_recover_i) begin
                version_head <= recover_checkpoint_i;
                // Distance from oldest copy, modulo the checkpoint ring
                num_checkpoints <= {1'b0, recover_checkpoint_i - version_tail};
            end else begin
                num_checkpoints <= num_checkpoints + checkpoint_enable - delete_enable;

                // Only the active copy consumes the read
                head[version_head]          <= head[version_head] + read_enable;
                num_registers[version_head] <= num_registers[version_head]
                                             + free_cnt_t'(wr_count) - read_enable;

                if (checkpoint_enable) begin
                    version_head                <= next_version;
                    head[next_version]          <= head[version_head] + read_enable;
                    num_registers[next_version] <= num_registers[version_head]
                                                 + free_cnt_t'(wr_count) - read_enable;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////

    // Bypass a released register when the active copy is empty
    always_comb begin
        if (!read_enable) begin
            new_register_o = '0;
        end else if (active_empty && write_enable_0) begin
            new_register_o = free_register_i[0];
        end else if (active_empty) begin
            new_register_o = free_register_i[1];
        end else begin
            new_register_o = register_table[head[version_head]];
        end
    end

    assign rename_grant_o       = read_enable;
    assign empty_o              = active_empty & ~write_enable_0 & ~write_enable_1;
    assign out_of_checkpoints_o = (num_checkpoints == vrename_pkg::NUM_CHECKPOINTS - 1);

endmodule

// File: rename_table/vreg_rename_table.sv
////////////////////////////////////////////////////////////////////////////
// Vector register rename table
// Speculative map copies per checkpoint plus a committed map
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vreg_rename_table (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          rename_grant_i,    // Free list accepted the read
    input  vrename_pkg::isa_vreg_t        src1_i,
    input  vrename_pkg::isa_vreg_t        src2_i,
    input  vrename_pkg::isa_vreg_t        dst_i,
    input  vrename_pkg::phvreg_t          new_phys_i,        // New name for dst_i
    input  logic                          commit_i,
    input  vrename_pkg::isa_vreg_t        commit_dst_i,
    input  vrename_pkg::phvreg_t          commit_phys_i,
    input  logic                          do_checkpoint_i,   // Already masked when full
    input  logic                          do_recover_i,
    input  vrename_pkg::checkpoint_ptr_t  recover_checkpoint_i,
    input  logic                          commit_roll_back_i,
    output vrename_pkg::phvreg_t          src1_phys_o,
    output vrename_pkg::phvreg_t          src2_phys_o,
    output vrename_pkg::phvreg_t          old_dst_phys_o
);

    // Speculative copies, one per checkpoint label
    vrename_pkg::phvreg_t spec_map [vrename_pkg::NUM_CHECKPOINTS][vrename_pkg::NUM_ISA_VREGS];

    // Committed architectural state
    vrename_pkg::phvreg_t commit_map [vrename_pkg::NUM_ISA_VREGS];

    vrename_pkg::checkpoint_ptr_t version;       // Active copy, tracks the free list
    vrename_pkg::checkpoint_ptr_t next_version;
    logic                         checkpoint_enable;

    assign next_version = version + 1'b1;

    // Same gating as the free list, the full check is done upstream
    assign checkpoint_enable = do_checkpoint_i & ~do_recover_i & ~commit_roll_back_i;

    ////////////////////////////////////////////////////////////////////////
    // Lookups, combinational from the active copy
    ////////////////////////////////////////////////////////////////////////

    assign src1_phys_o    = spec_map[version][src1_i];
    assign src2_phys_o    = spec_map[version][src2_i];
    assign old_dst_phys_o = spec_map[version][dst_i];   // Freed later by commit logic

    ////////////////////////////////////////////////////////////////////////
    // Map update
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            version <= '0;
            // Identity map in every copy
            for (int c = 0; c < vrename_pkg::NUM_CHECKPOINTS; c++) begin
                for (int r = 0; r < vrename_pkg::NUM_ISA_VREGS; r++) begin
                    spec_map[c][r] <= vrename_pkg::phvreg_t'(r);
                end
            end
            for (int r = 0; r < vrename_pkg::NUM_ISA_VREGS; r++) begin
                commit_map[r] <= vrename_pkg::phvreg_t'(r);
            end
        end else begin
            if (commit_i) begin
                commit_map[commit_dst_i] <= commit_phys_i;
            end

            if (commit_roll_back_i) begin
                version <= '0;
                // Copy 0 takes the committed map, including a commit in this cycle
                for (int r = 0; r < vrename_pkg::NUM_ISA_VREGS; r++) begin
                    if (commit_i && (commit_dst_i == vrename_pkg::isa_vreg_t'(r))) begin
                        spec_map[0][r] <= commit_phys_i;
                    end else begin
                        spec_map[0][r] <= commit_map[r];
                    end
                end
            end else if (do_recover_i) begin
                version <= recover_checkpoint_i;  // Older copy becomes active
            end else begin
                if (rename_grant_i) begin
                    spec_map[version][dst_i] <= new_phys_i;
                end

                if (checkpoint_enable) begin
                    version <= next_version;
                    // New copy starts from the active one after this rename
                    for (int r = 0; r < vrename_pkg::NUM_ISA_VREGS; r++) begin
                        if (rename_grant_i && (dst_i == vrename_pkg::isa_vreg_t'(r))) begin
                            spec_map[next_version][r] <= new_phys_i;
                        end else begin
                            spec_map[next_version][r] <= spec_map[version][r];
                        end
                    end
                end
            end
        end
    end

endmodule

// File: src/vrename_top.sv
////////////////////////////////////////////////////////////////////////////
// Vector register renaming top level
// Joins the rename table and the free list to the core ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vrename_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // Rename
    input  logic                          rename_i,
    input  vrename_pkg::isa_vreg_t        src1_i,
    input  vrename_pkg::isa_vreg_t        src2_i,
    input  vrename_pkg::isa_vreg_t        dst_i,
    // Release
    input  logic [1:0]                    release_valid_i,
    input  vrename_pkg::phvreg_t [1:0]    release_reg_i,
    // Commit
    input  logic                          commit_i,
    input  vrename_pkg::isa_vreg_t        commit_dst_i,
    input  vrename_pkg::phvreg_t          commit_phys_i,
    // Branch
    input  logic                          do_checkpoint_i,
    input  logic                          do_recover_i,
    input  vrename_pkg::checkpoint_ptr_t  recover_checkpoint_i,
    input  logic                          delete_checkpoint_i,
    input  logic                          commit_roll_back_i,
    // Results
    output vrename_pkg::phvreg_t          src1_phys_o,
    output vrename_pkg::phvreg_t          src2_phys_o,
    output vrename_pkg::phvreg_t          dst_phys_o,
    output vrename_pkg::phvreg_t          old_dst_phys_o,
    output vrename_pkg::checkpoint_ptr_t  checkpoint_o,
    output logic                          empty_o,
    output logic                          out_of_checkpoints_o
);

    logic rename_grant;     // Read took effect in the free list
    logic table_checkpoint;

    // Table keeps no checkpoint count, so it sees the strobe only when allowed
    assign table_checkpoint = do_checkpoint_i & ~out_of_checkpoints_o;

    vreg_free_list vreg_free_list_i (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (rename_i),
        .add_free_register_i  (release_valid_i),
        .free_register_i      (release_reg_i),
        .do_checkpoint_i      (do_checkpoint_i),
        .do_recover_i         (do_recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .commit_roll_back_i   (commit_roll_back_i),
        .new_register_o       (dst_phys_o),          // Also the table's new name
        .rename_grant_o       (rename_grant),
        .checkpoint_o         (checkpoint_o),
        .out_of_checkpoints_o (out_of_checkpoints_o),
        .empty_o              (empty_o)
    );

    vreg_rename_table vreg_rename_table_i (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .rename_grant_i       (rename_grant),
        .src1_i               (src1_i),
        .src2_i               (src2_i),
        .dst_i                (dst_i),
        .new_phys_i           (dst_phys_o),
        .commit_i             (commit_i),
        .commit_dst_i         (commit_dst_i),
        .commit_phys_i        (commit_phys_i),
        .do_checkpoint_i      (table_checkpoint),
        .do_recover_i         (do_recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .commit_roll_back_i   (commit_roll_back_i),
        .src1_phys_o          (src1_phys_o),
        .src2_phys_o          (src2_phys_o),
        .old_dst_phys_o       (old_dst_phys_o)
    );

endmodule

// File: bench/vrename_sva.sv
////////////////////////////////////////////////////////////////////////////
// Vector register free list assertions
// Bound into the free list, checks count range, empty reads and checkpoint limit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vreg_free_list_sva (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic [5:0]                    active_count_i,      // Count of the active copy
    input  logic [1:0]                    release_valid_i,     // Release strobes
    input  logic                          do_checkpoint_i,
    input  logic                          do_recover_i,
    input  logic                          commit_roll_back_i,
    input  logic                          out_of_checkpoints_i,
    input  vrename_pkg::checkpoint_ptr_t  version_head_i
);

    int assert_errors = 0;  // Assertion failures seen so far

    // List depth bounds every count
    count_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        active_count_i <= 6'(vrename_pkg::NUM_FREE_ENTRIES))
        else begin
            assert_errors++;
            $error("free count %0d above list depth", active_count_i);
        end

    // A read from an empty list with no release would wrap the count
    no_read_when_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (active_count_i == '0 && release_valid_i == 2'b00
         && !do_recover_i && !commit_roll_back_i)
        |=> (active_count_i == '0))
        else begin
            assert_errors++;
            $error("read granted from an empty free list");
        end

    // Full checkpoint ring keeps the active copy
    full_blocks_checkpoint: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (do_checkpoint_i && out_of_checkpoints_i && !do_recover_i && !commit_roll_back_i)
        |=> (version_head_i == $past(version_head_i)))
        else begin
            assert_errors++;
            $error("checkpoint taken with no free checkpoint copy");
        end

endmodule

bind vreg_free_list vreg_free_list_sva free_list_sva_i (
    .clk_i                (clk_i),
    .rstn_i               (rstn_i),
    .active_count_i       (num_registers[version_head]),
    .release_valid_i      (add_free_register_i),
    .do_checkpoint_i      (do_checkpoint_i),
    .do_recover_i         (do_recover_i),
    .commit_roll_back_i   (commit_roll_back_i),
    .out_of_checkpoints_i (out_of_checkpoints_o),
    .version_head_i       (version_head)
);

// File: bench/vrename_tb.sv
////////////////////////////////////////////////////////////////////////////
// Vector register renaming testbench
// Directed and random stimulus, reference model of map and free list
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vrename_tb;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 3;
    localparam int TEST_CYCLES   = 6 + 33 + 4 + 10 + 8 + 7;  // Per test, in run order
    localparam int MARGIN_CYCLES = 40;

    logic clk = 1'b0;
    logic rstn;
    logic rename;
    logic do_checkpoint;
    logic do_recover;
    logic delete_cp;
    logic roll_back;
    logic commit;
    logic [1:0] release_valid;
    vrename_pkg::isa_vreg_t src1;
    vrename_pkg::isa_vreg_t src2;
    vrename_pkg::isa_vreg_t dst;
    vrename_pkg::isa_vreg_t commit_dst;
    vrename_pkg::phvreg_t commit_phys;
    vrename_pkg::phvreg_t [1:0] release_reg;
    vrename_pkg::checkpoint_ptr_t recover_cp;
    vrename_pkg::phvreg_t src1_phys;
    vrename_pkg::phvreg_t src2_phys;
    vrename_pkg::phvreg_t dst_phys;
    vrename_pkg::phvreg_t old_dst_phys;
    vrename_pkg::checkpoint_ptr_t checkpoint;
    logic empty;
    logic out_of_cp;

    // Reference state, one map and one head and count per checkpoint
    int map_m [4][32];
    int commit_m [32];
    int ring [32];
    int head_m [4];
    int cnt_m [4];
    int tail_m;
    int vh_m;
    int vt_m;
    int nchk_m;
    int cp_out_m;

    int seed;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int errors_start;
    int checks_start;
    int saved_label;
    int assertion_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    vrename_top vrename_top_i (
        .clk_i                (clk),
        .rstn_i               (rstn),
        .rename_i             (rename),
        .src1_i               (src1),
        .src2_i               (src2),
        .dst_i                (dst),
        .release_valid_i      (release_valid),
        .release_reg_i        (release_reg),
        .commit_i             (commit),
        .commit_dst_i         (commit_dst),
        .commit_phys_i        (commit_phys),
        .do_checkpoint_i      (do_checkpoint),
        .do_recover_i         (do_recover),
        .recover_checkpoint_i (recover_cp),
        .delete_checkpoint_i  (delete_cp),
        .commit_roll_back_i   (roll_back),
        .src1_phys_o          (src1_phys),
        .src2_phys_o          (src2_phys),
        .dst_phys_o           (dst_phys),
        .old_dst_phys_o       (old_dst_phys),
        .checkpoint_o         (checkpoint),
        .empty_o              (empty),
        .out_of_checkpoints_o (out_of_cp)
    );

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    task automatic reset_model();
        for (int c = 0; c < 4; c++) begin
            head_m[c] = 0;
            cnt_m[c]  = 32;                  // Whole list free
            for (int r = 0; r < 32; r++) begin
                map_m[c][r] = r;             // Identity map
            end
        end
        for (int r = 0; r < 32; r++) begin
            commit_m[r] = r;
            ring[r]     = 32 + r;
        end
        tail_m   = 0;
        vh_m     = 0;
        vt_m     = 0;
        nchk_m   = 0;
        cp_out_m = 0;
    endtask

    function automatic bit read_granted();
        bit has_rel;
        has_rel = (release_valid != 2'b00) && !roll_back;
        return rename && ((cnt_m[vh_m] != 0) || has_rel) && !do_recover && !roll_back;
    endfunction

    function automatic int new_register_ref();
        if (!read_granted()) begin
            return 0;                        // Dropped rename
        end
        if (cnt_m[vh_m] == 0) begin
            return release_valid[0] ? release_reg[0] : release_reg[1];  // Bypass
        end
        return ring[head_m[vh_m]];
    endfunction

    // Expected {src1, src2, dst, old dst, checkpoint, empty, out of checkpoints}
    function automatic logic [27:0] expected_outputs();
        logic empty_exp;
        empty_exp = (cnt_m[vh_m] == 0) && !((release_valid != 2'b00) && !roll_back);
        return {6'(map_m[vh_m][src1]), 6'(map_m[vh_m][src2]), 6'(new_register_ref()),
                6'(map_m[vh_m][dst]), 2'(cp_out_m), empty_exp, nchk_m == 3};
    endfunction

    // Advance the model across the coming rising edge
    task automatic update_model();
        int n_rel;
        int new_reg;
        int nv;
        bit grant;
        bit cp_en;
        bit del_en;
        grant   = read_granted();
        new_reg = new_register_ref();
        if (commit) begin
            commit_m[commit_dst] = commit_phys;
        end
        if (roll_back) begin
            for (int r = 0; r < 32; r++) begin
                map_m[0][r] = commit_m[r];
            end
            head_m[0] = tail_m;              // Everything after commit is free again
            cnt_m[0]  = 32;
            vh_m      = 0;
            vt_m      = 0;
            nchk_m    = 0;
            cp_out_m  = 0;
        end else begin
            cp_en  = do_checkpoint && (nchk_m != 3) && !do_recover;
            del_en = delete_cp && (nchk_m != 0) && !do_recover;
            n_rel  = 0;
            for (int p = 0; p < 2; p++) begin
                if (release_valid[p]) begin
                    ring[(tail_m + n_rel) % 32] = release_reg[p];
                    n_rel++;
                end
            end
            tail_m = (tail_m + n_rel) % 32;
            for (int c = 0; c < 4; c++) begin
                cnt_m[c] += n_rel;           // Releases count in every copy
            end
            cp_out_m = vh_m;
            vt_m     = (vt_m + del_en) % 4;
            if (do_recover) begin
                vh_m   = recover_cp;
                nchk_m = (recover_cp - vt_m + 4) % 4;
            end else begin
                nchk_m = nchk_m + cp_en - del_en;
                if (grant) begin
                    head_m[vh_m] = (head_m[vh_m] + 1) % 32;
                    cnt_m[vh_m]--;
                    map_m[vh_m][dst] = new_reg;
                end
                if (cp_en) begin
                    nv         = (vh_m + 1) % 4;
                    head_m[nv] = head_m[vh_m];
                    cnt_m[nv]  = cnt_m[vh_m];
                    for (int r = 0; r < 32; r++) begin
                        map_m[nv][r] = map_m[vh_m][r];
                    end
                    vh_m = nv;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Comparing process, outputs settle well before the falling edge
    ////////////////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        logic [27:0] exp_v;
        if (rstn) begin
            exp_v = expected_outputs();
            check_field("src1_phys_o", src1_phys, exp_v[27:22]);
            check_field("src2_phys_o", src2_phys, exp_v[21:16]);
            check_field("dst_phys_o", dst_phys, exp_v[15:10]);
            check_field("old_dst_phys_o", old_dst_phys, exp_v[9:4]);
            check_field("checkpoint_o", checkpoint, exp_v[3:2]);
            check_field("empty_o", empty, exp_v[1]);
            check_field("out_of_checkpoints_o", out_of_cp, exp_v[0]);
            update_model();
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////

    // Strobes drop to idle every cycle unless the caller sets them again
    task automatic tick();
        @(posedge clk);
        #0.5;
        rename        = 1'b0;
        release_valid = 2'b00;
        commit        = 1'b0;
        do_checkpoint = 1'b0;
        do_recover    = 1'b0;
        delete_cp     = 1'b0;
        roll_back     = 1'b0;
    endtask

    task automatic rename_random();
        tick();
        rename = 1'b1;
        src1   = 5'($random(seed));
        src2   = 5'($random(seed));
        dst    = 5'($random(seed));
    endtask

    task automatic release_random(input logic [1:0] valid);
        release_valid  = valid;
        release_reg[0] = 6'($random(seed));
        release_reg[1] = 6'($random(seed));
    endtask

    task automatic start_test();
        errors_start = errors;
        checks_start = checks;
    endtask

    task automatic finish_test(input string name);
        tick();
        @(negedge clk);
        #0.1;                                // Let the last compare finish
        tests++;
        $display("test %0d %s: %0d checks, %s", tests, name, checks - checks_start,
                 (errors == errors_start) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////

    initial begin
        seed          = 32'h6d02_7201;
        rstn          = 1'b0;
        rename        = 1'b0;
        src1          = '0;
        src2          = '0;
        dst           = '0;
        release_valid = 2'b00;
        release_reg   = '0;
        commit        = 1'b0;
        commit_dst    = '0;
        commit_phys   = '0;
        do_checkpoint = 1'b0;
        do_recover    = 1'b0;
        recover_cp    = '0;
        delete_cp     = 1'b0;
        roll_back     = 1'b0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rstn = 1'b1;

        // Identity lookups, then names from 32 upward
        start_test();
        tick();
        src1 = 5'd3;
        src2 = 5'd17;
        repeat (4) rename_random();
        finish_test("reset map and first renames");

        // Released names queue behind the initial ones, last rename bypasses
        start_test();
        tick();
        release_random(2'b11);
        repeat (30) rename_random();
        rename_random();
        release_random(2'b01);
        finish_test("free list reuse and bypass");

        start_test();
        repeat (3) rename_random();          // Dropped, list is empty
        finish_test("empty list drops renames");

        // Renames after a checkpoint are undone by the recover
        start_test();
        repeat (3) begin
            tick();
            release_random(2'b11);
        end
        tick();
        do_checkpoint = 1'b1;
        saved_label   = vh_m;
        rename_random();
        rename_random();
        release_random(2'b01);               // Stays counted after the recover
        rename_random();
        tick();
        do_recover = 1'b1;
        recover_cp = 2'(saved_label);
        rename_random();
        finish_test("checkpoint and recover");

        // Fourth checkpoint is ignored until a delete frees a copy
        start_test();
        repeat (4) begin
            tick();
            do_checkpoint = 1'b1;
        end
        tick();
        tick();
        delete_cp = 1'b1;
        tick();
        finish_test("checkpoint limit and delete");

        start_test();
        rename_random();
        commit      = 1'b1;
        commit_dst  = 5'd5;
        commit_phys = 6'd40;
        rename_random();
        rename_random();
        commit      = 1'b1;
        commit_dst  = 5'($random(seed));
        commit_phys = 6'($random(seed));
        rename_random();
        tick();
        roll_back = 1'b1;
        rename_random();                     // Takes the name at the old tail
        finish_test("commit roll back");

        assertion_errors = vrename_top_i.vreg_free_list_i.free_list_sva_i.assert_errors;
        $display("tests %0d, checks %0d, errors %0d, assertion errors %0d",
                 tests, checks, errors, assertion_errors);
        if (errors == 0 && assertion_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Run timed out at %0t before the tests finished", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: list.f
common/vrename_pkg.sv
free_list/vreg_free_list.sv
rename_table/vreg_rename_table.sv
src/vrename_top.sv
bench/vrename_sva.sv
bench/vrename_tb.sv
